// File: design/apu_bus_pkg.sv
package apu_bus_pkg;

// ******************************
// register map
// ******************************

typedef enum logic [4:0] {
	P0_CTRL     = 5'd0,
	P0_TIMER_LO = 5'd1,
	P0_TIMER_HI = 5'd2,
	P1_CTRL     = 5'd4,
	P1_TIMER_LO = 5'd5,
	P1_TIMER_HI = 5'd6,
	STATUS      = 5'd8,
	FRAME       = 5'd9
} apu_reg_e;

// status byte and frame register bit positions
localparam int STATUS_INT_BIT = 6;
localparam int FRAME_MODE_BIT = 7;
localparam int FRAME_INHIBIT_BIT = 6;

// ******************************
// host port payload
// ******************************

typedef struct packed {
	logic we;
	apu_reg_e addr;
	logic [7:0] wdata;
} apu_bus_req_t;

typedef struct packed {
	logic [7:0] rdata;
} apu_bus_rsp_t;

endpackage

// File: design/apu_audio_pkg.sv
package apu_audio_pkg;

// ******************************
// timing
// ******************************

// kept short so a frame fits a short simulation
localparam int FRAME_STEP_CYCLES = 64;
localparam int FRAME_CNT_W = $clog2(FRAME_STEP_CYCLES);
localparam int NUM_PULSE = 2;

typedef enum logic [2:0] {S0, S1, S2, S3, S4} frame_state_e;

// ******************************
// channel types
// ******************************

typedef enum logic [1:0] {
	DUTY_12 = 2'd0,
	DUTY_25 = 2'd1,
	DUTY_50 = 2'd2,
	DUTY_75 = 2'd3
} duty_e;

typedef struct packed {
	duty_e duty;
	logic [3:0] volume;
	logic [10:0] period;
} pulse_cfg_t;

typedef struct packed {
	logic quarter;
	logic half;
} frame_tick_t;

endpackage

// File: design/apu_reg_port.sv
`timescale 1ns/1ns

module apu_reg_port
	import apu_bus_pkg::*;
	import apu_audio_pkg::*;
(
	input logic clk,
	input logic n_reset,
	input logic req,
	input apu_bus_req_t bus_req,
	output logic ack,
	output apu_bus_rsp_t bus_rsp,
	input logic active [NUM_PULSE],
	input logic frame_int,
	output pulse_cfg_t pulse_cfg [NUM_PULSE],
	output logic len_load [NUM_PULSE],
	output logic [4:0] len_value,
	output logic chan_en [NUM_PULSE],
	output logic frame_mode,
	output logic frame_inhibit,
	output logic frame_restart,
	output logic status_read
);

typedef enum logic [1:0] {IDLE, ACCESS, ACK} port_state_e;

port_state_e state;
apu_bus_req_t req_q;
logic ch;
logic write_acc;
logic [7:0] status;

// ******************************
// four-phase handshake
// ******************************

always_ff @(posedge clk, negedge n_reset) begin
	if (!n_reset) begin
		state <= IDLE;
	end else begin
		case (state)
			IDLE: if (req) state <= ACCESS;
			ACCESS: state <= ACK;
			ACK: if (!req) state <= IDLE;
			default: state <= IDLE;
		endcase
	end
end

// request is stable while req is high, so one capture is enough
always_ff @(posedge clk) begin
	if (state == IDLE && req)
		req_q <= bus_req;
end

assign ack = state == ACK;
assign ch = req_q.addr[2];
assign write_acc = state == ACCESS && req_q.we;
assign status_read = state == ACCESS && !req_q.we && req_q.addr == STATUS;
assign frame_restart = write_acc && req_q.addr == FRAME;
assign len_value = req_q.wdata[7:3];

always_comb begin
	status = '0;
	for (int i = 0; i < NUM_PULSE; i++)
		status[i] = active[i];
	status[STATUS_INT_BIT] = frame_int;
end

// flag captured before the sequencer clears it on the same edge
always_ff @(posedge clk, negedge n_reset) begin
	if (!n_reset)
		bus_rsp <= '0;
	else if (state == ACCESS)
		bus_rsp.rdata <= status_read ? status : 8'h00;
end

always_comb begin
	for (int i = 0; i < NUM_PULSE; i++)
		len_load[i] = 1'b0;
	if (write_acc && (req_q.addr == P0_TIMER_HI || req_q.addr == P1_TIMER_HI))
		len_load[ch] = 1'b1;
end

// ******************************
// register storage
// ******************************

always_ff @(posedge clk, negedge n_reset) begin
	if (!n_reset) begin
		for (int i = 0; i < NUM_PULSE; i++) begin
			pulse_cfg[i] <= '0;
			chan_en[i] <= 1'b0;
		end
		frame_mode <= 1'b0;
		frame_inhibit <= 1'b0;
	end else if (write_acc) begin
		case (req_q.addr)
			P0_CTRL, P1_CTRL: begin
				pulse_cfg[ch].duty <= duty_e'(req_q.wdata[7:6]);
				pulse_cfg[ch].volume <= req_q.wdata[3:0];
			end
			P0_TIMER_LO, P1_TIMER_LO: pulse_cfg[ch].period[7:0] <= req_q.wdata;
			P0_TIMER_HI, P1_TIMER_HI: pulse_cfg[ch].period[10:8] <= req_q.wdata[2:0];
			STATUS: begin
				for (int i = 0; i < NUM_PULSE; i++)
					chan_en[i] <= req_q.wdata[i];
			end
			FRAME: begin
				frame_mode <= req_q.wdata[FRAME_MODE_BIT];
				frame_inhibit <= req_q.wdata[FRAME_INHIBIT_BIT];
			end
			default: ;
		endcase
	end
end

endmodule

// File: design/apu_frame_sequencer.sv
`timescale 1ns/1ns

module apu_frame_sequencer
	import apu_audio_pkg::*;
(
	input logic clk,
	input logic n_reset,
	input logic frame_mode,
	input logic frame_inhibit,
	input logic frame_restart,
	input logic status_read,
	output frame_tick_t frame_tick,
	output logic frame_int
);

frame_state_e state;
logic [FRAME_CNT_W-1:0] step_cnt;
logic step_end;

// ******************************
// step counter
// ******************************

assign step_end = step_cnt == FRAME_CNT_W'(FRAME_STEP_CYCLES - 1);

always_ff @(posedge clk, negedge n_reset) begin
	if (!n_reset)
		step_cnt <= '0;
	else if (frame_restart || step_end)
		step_cnt <= '0;
	else
		step_cnt <= step_cnt + 1'b1;
end

// ******************************
// frame state machine
// ******************************

always_ff @(posedge clk, negedge n_reset) begin
	if (!n_reset) begin
		state <= S0;
	end else if (frame_restart) begin
		state <= S0;
	end else if (step_end) begin
		case (state)
			S0: state <= S1;
			S1: state <= S2;
			S2: state <= S3;
			S3: state <= frame_mode ? S4 : S0;
			default: state <= S0;
		endcase
	end
end

// five-step mode skips the quarter tick in S3
always_ff @(posedge clk, negedge n_reset) begin
	if (!n_reset) begin
		frame_tick <= '0;
	end else if (step_end && !frame_restart) begin
		frame_tick.quarter <= !(frame_mode && state == S3);
		case (state)
			S1: frame_tick.half <= 1'b1;
			S3: frame_tick.half <= !frame_mode;
			S4: frame_tick.half <= 1'b1;
			default: frame_tick.half <= 1'b0;
		endcase
	end else begin
		frame_tick <= '0;
	end
end

// interrupt is raised when leaving the last step of a four-step frame
always_ff @(posedge clk, negedge n_reset) begin
	if (!n_reset)
		frame_int <= 1'b0;
	else if (step_end && !frame_restart && state == S3 && !frame_mode && !frame_inhibit)
		frame_int <= 1'b1;
	else if (frame_inhibit || status_read)
		frame_int <= 1'b0;
end

endmodule

// File: design/apu_pulse.sv
`timescale 1ns/1ns

module apu_pulse
	import apu_audio_pkg::*;
(
	input logic clk,
	input logic n_reset,
	input pulse_cfg_t cfg,
	input frame_tick_t frame_tick,
	input logic len_load,
	input logic chan_en,
	input logic [4:0] len_value,
	output logic [3:0] sample,
	output logic active
);

logic [10:0] timer;
logic [2:0] step;
logic [4:0] len_cnt;
logic [7:0] pattern;
logic duty_bit;

// ******************************
// timer and duty sequencer
// ******************************

always_ff @(posedge clk, negedge n_reset) begin
	if (!n_reset) begin
		timer <= '0;
		step <= '0;
	end else if (timer == '0) begin
		timer <= cfg.period;
		step <= step + 1'b1;
	end else begin
		timer <= timer - 1'b1;
	end
end

always_comb begin
	case (cfg.duty)
		DUTY_12: pattern = 8'b0100_0000;
		DUTY_25: pattern = 8'b0110_0000;
		DUTY_50: pattern = 8'b0111_1000;
		DUTY_75: pattern = 8'b1001_1111;
		default: pattern = 8'b0000_0000;
	endcase
end

// step 0 is the leftmost bit of the pattern
assign duty_bit = pattern[3'd7 - step];

// ******************************
// length counter
// ******************************

always_ff @(posedge clk, negedge n_reset) begin
	if (!n_reset)
		len_cnt <= '0;
	else if (!chan_en)
		len_cnt <= '0;
	else if (len_load)
		len_cnt <= len_value;
	else if (frame_tick.half && len_cnt != '0)
		len_cnt <= len_cnt - 1'b1;
end

assign active = len_cnt != '0;

// constant volume without an envelope
always_ff @(posedge clk, negedge n_reset) begin
	if (!n_reset)
		sample <= '0;
	else if (active && duty_bit)
		sample <= cfg.volume;
	else
		sample <= '0;
end

endmodule

// File: design/apu_mixer.sv
`timescale 1ns/1ns

module apu_mixer
	import apu_audio_pkg::*;
(
	input logic clk,
	input logic n_reset,
	input logic [3:0] sample [NUM_PULSE],
	output logic [7:0] sample_out
);

logic [7:0] sum;

// more channels just extend the linear sum
always_comb begin
	sum = '0;
	for (int i = 0; i < NUM_PULSE; i++)
		sum = sum + 8'(sample[i]);
end

always_ff @(posedge clk, negedge n_reset) begin
	if (!n_reset)
		sample_out <= '0;
	else
		sample_out <= sum;
end

endmodule

// File: design/apu_top.sv
`timescale 1ns/1ns

module apu_top
	import apu_bus_pkg::*;
	import apu_audio_pkg::*;
(
	input logic clk,
	input logic n_reset,
	input logic req,
	input apu_bus_req_t bus_req,
	output logic ack,
	output apu_bus_rsp_t bus_rsp,
	output logic irq,
	output logic [7:0] sample_out
);

pulse_cfg_t pulse_cfg [NUM_PULSE];
logic len_load [NUM_PULSE];
logic chan_en [NUM_PULSE];
logic active [NUM_PULSE];
logic [3:0] sample [NUM_PULSE];
logic [4:0] len_value;
logic frame_mode;
logic frame_inhibit;
logic frame_restart;
logic status_read;
frame_tick_t frame_tick;

apu_reg_port i_reg_port (
	.clk(clk),
	.n_reset(n_reset),
	.req(req),
	.bus_req(bus_req),
	.ack(ack),
	.bus_rsp(bus_rsp),
	.active(active),
	.frame_int(irq),
	.pulse_cfg(pulse_cfg),
	.len_load(len_load),
	.len_value(len_value),
	.chan_en(chan_en),
	.frame_mode(frame_mode),
	.frame_inhibit(frame_inhibit),
	.frame_restart(frame_restart),
	.status_read(status_read)
);

apu_frame_sequencer i_frame_sequencer (
	.clk(clk),
	.n_reset(n_reset),
	.frame_mode(frame_mode),
	.frame_inhibit(frame_inhibit),
	.frame_restart(frame_restart),
	.status_read(status_read),
	.frame_tick(frame_tick),
	.frame_int(irq)
);

for (genvar i = 0; i < NUM_PULSE; i++) begin : g_pulse
	apu_pulse i_pulse (
		.clk(clk),
		.n_reset(n_reset),
		.cfg(pulse_cfg[i]),
		.frame_tick(frame_tick),
		.len_load(len_load[i]),
		.chan_en(chan_en[i]),
		.len_value(len_value),
		.sample(sample[i]),
		.active(active[i])
	);
end

apu_mixer i_mixer (
	.clk(clk),
	.n_reset(n_reset),
	.sample(sample),
	.sample_out(sample_out)
);

endmodule

// File: verification/apu_checker.sv
`timescale 1ns/1ns

module apu_checker
	import apu_audio_pkg::*;
(
	input logic clk,
	input logic n_reset,
	input logic req,
	input logic ack,
	input logic irq,
	input frame_tick_t frame_tick,
	input logic frame_mode
);

int fail_count = 0;

// ******************************
// host handshake
// ******************************

ack_rise: assert property (@(posedge clk) disable iff (!n_reset) $rose(ack) |-> req)
	else begin
		fail_count++;
		$error("ack rose while req was low");
	end

ack_fall: assert property (@(posedge clk) disable iff (!n_reset) $fell(ack) |-> !$past(req))
	else begin
		fail_count++;
		$error("ack fell before req was dropped");
	end

reset_state: assert property (@(posedge clk) $rose(n_reset) |-> !ack && !irq)
	else begin
		fail_count++;
		$error("ack or irq high when leaving reset");
	end

// four-step frames only
half_tick: assert property (@(posedge clk) disable iff (!n_reset)
	frame_tick.half && !frame_mode |-> frame_tick.quarter)
	else begin
		fail_count++;
		$error("half tick without quarter tick");
	end

endmodule

bind apu_top apu_checker i_checker (
	.clk(clk),
	.n_reset(n_reset),
	.req(req),
	.ack(ack),
	.irq(irq),
	.frame_tick(frame_tick),
	.frame_mode(frame_mode)
);

// File: verification/apu_tb.sv
`timescale 1ns/1ns

module apu_tb
	import apu_bus_pkg::*;
	import apu_audio_pkg::*;
();

localparam int BUS_LIMIT = 16;
localparam int FRAME4 = 4 * FRAME_STEP_CYCLES;
localparam int FRAME5 = 5 * FRAME_STEP_CYCLES;

// W_NONE rows do one bus access while all others only wait or observe
typedef enum logic [2:0] {W_NONE, W_STATUS, W_IRQ, W_QUIET, W_PEAK} wait_e;

typedef struct packed {
	int test;
	apu_reg_e addr;
	logic we;
	logic [7:0] data;
	logic [7:0] exp;
	logic check;
	wait_e kind;
	int sel;
	logic val;
	int limit;
} row_t;

logic clk;
logic n_reset;
logic req;
apu_bus_req_t bus_req;
logic ack;
apu_bus_rsp_t bus_rsp;
logic irq;
logic [7:0] sample_out;

int cycle;
integer seed;
int passes;
int fails;
int test_errors;
row_t rows[$];

apu_top i_dut (.*);

initial begin
	clk = 1'b0;
	forever #2 clk = ~clk;
end

always @(posedge clk)
	cycle <= cycle + 1;

function automatic row_t bus_row(int test, apu_reg_e addr, logic we, logic [7:0] data,
		logic [7:0] exp, logic check);
	row_t r;
	r = '0;
	r.test = test;
	r.addr = addr;
	r.we = we;
	r.data = data;
	r.exp = exp;
	r.check = check;
	return r;
endfunction

function automatic row_t wait_row(int test, wait_e kind, int sel, logic val, int limit,
		logic [7:0] exp);
	row_t r;
	r = '0;
	r.test = test;
	r.kind = kind;
	r.sel = sel;
	r.val = val;
	r.limit = limit;
	r.exp = exp;
	return r;
endfunction

function automatic void tally(input logic good);
	if (good) begin
		passes++;
	end else begin
		fails++;
		test_errors++;
	end
endfunction

// ******************************
// four-phase host access
// ******************************

task automatic bus_access(input apu_reg_e addr, input logic we, input logic [7:0] data,
		output logic [7:0] rdata, output logic ok);
	apu_bus_req_t r;
	int n;
	r.we = we;
	r.addr = addr;
	r.wdata = data;
	ok = 1'b0;
	rdata = 8'h00;
	@(posedge clk);
	req <= 1'b1;
	bus_req <= r;
	n = 0;
	do begin
		@(negedge clk);
		n++;
	end while (!ack && n < BUS_LIMIT);
	if (!ack) begin
		$display("no ack within %0d cycles for access to %s", BUS_LIMIT, addr.name());
		tally(1'b0);
	end else begin
		rdata = bus_rsp.rdata;
		ok = 1'b1;
	end
	@(posedge clk);
	req <= 1'b0;
	n = 0;
	do begin
		@(negedge clk);
		n++;
	end while (ack && n < BUS_LIMIT);
	if (ack) begin
		$display("ack stayed high after req was dropped for access to %s", addr.name());
		tally(1'b0);
	end
endtask

task automatic run_wait(input row_t r);
	int start;
	logic hit;
	logic ok;
	logic [7:0] rd;
	logic [7:0] peak;
	start = cycle;
	hit = 1'b0;
	peak = 8'h00;
	case (r.kind)
		W_STATUS: begin
			while (!hit && cycle - start < r.limit) begin
				bus_access(STATUS, 1'b0, 8'h00, rd, ok);
				hit = ok && rd[r.sel] == r.val;
			end
			if (!hit)
				$display("status bit %0d did not reach %0b within %0d cycles", r.sel, r.val,
					r.limit);
			tally(hit);
		end
		W_IRQ: begin
			while (!hit && cycle - start < r.limit) begin
				@(negedge clk);
				hit = irq == r.val;
			end
			if (!hit)
				$display("irq did not reach %0b within %0d cycles", r.val, r.limit);
			tally(hit);
		end
		W_QUIET: begin
			hit = 1'b1;
			repeat (r.limit) begin
				@(negedge clk);
				if (irq)
					hit = 1'b0;
			end
			if (!hit)
				$display("irq went high during a %0d cycle window", r.limit);
			tally(hit);
		end
		W_PEAK: begin
			repeat (r.limit) begin
				@(negedge clk);
				if (sample_out > peak)
					peak = sample_out;
			end
			if (peak !== r.exp)
				$display("Mismatch at %0t ns: sample_out peak expected %02h got %02h", $time,
					r.exp, peak);
			tally(peak === r.exp);
		end
		default: ;
	endcase
endtask

// ******************************
// test table and main flow
// ******************************

initial begin
	logic [3:0] vol0;
	logic [3:0] vol1;
	logic [7:0] period;
	logic [7:0] rd;
	logic ok;
	n_reset = 1'b0;
	req = 1'b0;
	bus_req = '0;
	seed = 32'hbe8d;
	vol0 = 4'($random(seed));
	vol1 = 4'($random(seed));
	period = 8'(($random(seed) & 7) + 2);

	// reset state
	rows.push_back(bus_row(1, STATUS, 1'b0, 8'h00, 8'h00, 1'b1));
	rows.push_back(wait_row(1, W_IRQ, 0, 1'b0, 2, 8'h00));
	rows.push_back(wait_row(1, W_PEAK, 0, 1'b0, 16, 8'h00));
	// length counter of channel 0 with the frame irq inhibited
	rows.push_back(bus_row(2, FRAME, 1'b1, 8'h40, 8'h00, 1'b1));
	rows.push_back(bus_row(2, STATUS, 1'b1, 8'h01, 8'h00, 1'b1));
	rows.push_back(bus_row(2, P0_TIMER_HI, 1'b1, 8'h18, 8'h00, 1'b1));
	rows.push_back(bus_row(2, STATUS, 1'b0, 8'h00, 8'h01, 1'b1));
	rows.push_back(wait_row(2, W_STATUS, 0, 1'b0, 4 * FRAME4, 8'h00));
	rows.push_back(bus_row(2, P0_TIMER_HI, 1'b1, 8'h18, 8'h00, 1'b1));
	rows.push_back(bus_row(2, STATUS, 1'b0, 8'h00, 8'h01, 1'b1));
	rows.push_back(bus_row(2, STATUS, 1'b1, 8'h00, 8'h00, 1'b1));
	rows.push_back(bus_row(2, STATUS, 1'b0, 8'h00, 8'h00, 1'b1));
	// four-step frame interrupt and its clear on a status read
	rows.push_back(bus_row(3, FRAME, 1'b1, 8'h00, 8'h00, 1'b1));
	rows.push_back(wait_row(3, W_IRQ, 0, 1'b1, FRAME4 + 8, 8'h00));
	rows.push_back(bus_row(3, STATUS, 1'b0, 8'h00, 8'h40, 1'b1));
	rows.push_back(wait_row(3, W_IRQ, 0, 1'b0, 4, 8'h00));
	rows.push_back(bus_row(3, STATUS, 1'b0, 8'h00, 8'h00, 1'b1));
	// five-step mode and then four-step with inhibit
	rows.push_back(bus_row(4, FRAME, 1'b1, 8'h80, 8'h00, 1'b1));
	rows.push_back(wait_row(4, W_QUIET, 0, 1'b0, 3 * FRAME5, 8'h00));
	rows.push_back(bus_row(4, FRAME, 1'b1, 8'h40, 8'h00, 1'b1));
	rows.push_back(wait_row(4, W_QUIET, 0, 1'b0, 3 * FRAME4, 8'h00));
	rows.push_back(bus_row(4, STATUS, 1'b0, 8'h00, 8'h00, 1'b1));
	// both channels at duty 75 with max length
	rows.push_back(bus_row(5, STATUS, 1'b1, 8'h03, 8'h00, 1'b1));
	rows.push_back(bus_row(5, P0_CTRL, 1'b1, {4'hc, vol0}, 8'h00, 1'b1));
	rows.push_back(bus_row(5, P0_TIMER_LO, 1'b1, period, 8'h00, 1'b1));
	rows.push_back(bus_row(5, P0_TIMER_HI, 1'b1, 8'hf8, 8'h00, 1'b1));
	rows.push_back(bus_row(5, P1_CTRL, 1'b1, {4'hc, vol1}, 8'h00, 1'b1));
	rows.push_back(bus_row(5, P1_TIMER_LO, 1'b1, period, 8'h00, 1'b1));
	rows.push_back(bus_row(5, P1_TIMER_HI, 1'b1, 8'hf8, 8'h00, 1'b1));
	rows.push_back(wait_row(5, W_PEAK, 0, 1'b0, 8 * (int'(period) + 1) + 8,
		8'(vol0) + 8'(vol1)));
	rows.push_back(bus_row(5, STATUS, 1'b1, 8'h00, 8'h00, 1'b1));
	rows.push_back(wait_row(5, W_PEAK, 0, 1'b0, 16, 8'h00));

	repeat (2) @(posedge clk);
	n_reset <= 1'b1;

	foreach (rows[i]) begin
		if (rows[i].kind == W_NONE) begin
			bus_access(rows[i].addr, rows[i].we, rows[i].data, rd, ok);
			if (ok && rows[i].check) begin
				if (rd !== rows[i].exp) begin
					$display("Mismatch at %0t ns: bus_rsp.rdata for %s expected %02h got %02h",
						$time, rows[i].addr.name(), rows[i].exp, rd);
					tally(1'b0);
				end else begin
					tally(1'b1);
				end
			end
		end else begin
			run_wait(rows[i]);
		end
		if (i == rows.size() - 1 || rows[i + 1].test != rows[i].test) begin
			$display("test %0d done, %0d errors", rows[i].test, test_errors);
			test_errors = 0;
		end
	end

	if (i_dut.i_checker.fail_count != 0) begin
		$display("%0d assertion failures reported by the checker",
			i_dut.i_checker.fail_count);
		fails += i_dut.i_checker.fail_count;
	end
	$display("checks passed: %0d, checks failed: %0d", passes, fails);
	if (fails == 0)
		$display("SIMULATION PASSED");
	else
		$display("SIMULATION FAILED");
	$finish;
end

endmodule

// File: compile.f
design/apu_bus_pkg.sv
design/apu_audio_pkg.sv
design/apu_reg_port.sv
design/apu_frame_sequencer.sv
design/apu_pulse.sv
design/apu_mixer.sv
design/apu_top.sv
verification/apu_checker.sv
verification/apu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= apu_tb
FLAGS ?= --assert

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing $(FLAGS) --top-module $(TOP) -f compile.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir
